// ==== logic/fe_defines.svh ====
`ifndef FE_DEFINES_SVH
`define FE_DEFINES_SVH

// Virtual pc width
`define FE_VADDR_W 32

// Instruction word width
`define FE_INSTR_W 32

// Byte step between sequential fetches
`define FE_PC_STEP 4

`endif

// ==== logic/fe_cmd_pkg.sv ====
`default_nettype none

`include "fe_defines.svh"

package fe_cmd_pkg;

  typedef enum logic
  {
    e_op_pc_redirect = 1'b0,
    e_op_halt        = 1'b1
  } fe_cmd_opcode_e;

  // Target vaddr is ignored for halt
  typedef struct packed
  {
    fe_cmd_opcode_e          opcode;
    logic [`FE_VADDR_W-1:0]  vaddr;
  } fe_cmd_s;

endpackage

`default_nettype wire

// ==== logic/fe_queue_pkg.sv ====
`default_nettype none

`include "fe_defines.svh"

package fe_queue_pkg;

  typedef enum logic
  {
    e_fe_fetch     = 1'b0,
    e_fe_exception = 1'b1
  } fe_msg_type_e;

  typedef enum logic [7:0]
  {
    e_instr_misaligned   = 8'h00,
    e_instr_access_fault = 8'h01
  } fe_exc_code_e;

  typedef struct packed
  {
    logic [`FE_VADDR_W-1:0]  pc;
    logic [`FE_INSTR_W-1:0]  instr;
  } fe_fetch_msg_s;

  typedef struct packed
  {
    logic [`FE_VADDR_W-1:0]  vaddr;
    fe_exc_code_e            exception_code;
    logic [23:0]             padding;
  } fe_exception_msg_s;

  // Same 64 bits read as a fetch or as an exception
  typedef union packed
  {
    fe_fetch_msg_s      fetch;
    fe_exception_msg_s  exception;
  } fe_queue_msg_u;

  typedef struct packed
  {
    fe_msg_type_e   msg_type;
    fe_queue_msg_u  msg;
  } fe_queue_s;

endpackage

`default_nettype wire

// ==== logic/fe_pc_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

interface fe_pc_if;

  // Address of the next fetch and always valid
  logic [`FE_VADDR_W-1:0] next_pc;
  logic                   next_pc_yumi;

  // Redirect wins over yumi
  logic                   redirect_v;
  logic [`FE_VADDR_W-1:0] redirect_pc;

  modport gen
  (
    output next_pc,
    input  next_pc_yumi,
    input  redirect_v,
    input  redirect_pc
  );

  modport ctrl
  (
    input  next_pc,
    output next_pc_yumi,
    output redirect_v,
    output redirect_pc
  );

endinterface

`default_nettype wire

// ==== logic/fe_pc_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

module fe_pc_gen
(
  input  logic      clk_i,
  input  logic      reset_i,
  fe_pc_if.gen      pc_io
);

  logic [`FE_VADDR_W-1:0] pc_r;

  // Redirect takes priority over a sequential step
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pc_r <= '0;
    end
    else if (pc_io.redirect_v)
    begin
      pc_r <= pc_io.redirect_pc;
    end
    else if (pc_io.next_pc_yumi)
    begin
      pc_r <= pc_r + `FE_VADDR_W'(`FE_PC_STEP);
    end
  end

  assign pc_io.next_pc = pc_r;

  // An aligned pc stays aligned through steps and aligned redirects
  property p_pc_stays_aligned;
    @(posedge clk_i) disable iff (reset_i)
      ((pc_r[1:0] == 2'b00)
        && !(pc_io.redirect_v && (pc_io.redirect_pc[1:0] != 2'b00)))
      |=> (pc_r[1:0] == 2'b00);
  endproperty

  a_pc_stays_aligned: assert property (p_pc_stays_aligned)
    else $error("pc lost alignment: %h", pc_r);

endmodule

`default_nettype wire

// ==== logic/fe_fetch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

module fe_fetch_ctrl
(
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  fe_cmd_pkg::fe_cmd_s        fe_cmd_i,
  input  logic                       fe_cmd_v_i,
  output logic                       fe_cmd_yumi_o,

  output fe_queue_pkg::fe_queue_s    fe_queue_o,
  output logic                       fe_queue_v_o,
  input  logic                       fe_queue_ready_i,

  output logic [`FE_VADDR_W-1:0]     wb_adr_o,
  output logic                       wb_cyc_o,
  output logic                       wb_stb_o,
  output logic                       wb_we_o,
  input  logic [`FE_INSTR_W-1:0]     wb_dat_i,
  input  logic                       wb_ack_i,
  input  logic                       wb_err_i,

  fe_pc_if.ctrl                      pc_io
);

  import fe_cmd_pkg::*;
  import fe_queue_pkg::*;

  typedef enum logic [1:0] {e_wait, e_run, e_stall} state_e;

  state_e    state_r, state_n;
  logic      cyc_r;
  logic      queue_v_r;
  fe_queue_s queue_r, queue_n;

  wire is_run     = (state_r == e_run);
  wire is_stall   = (state_r == e_stall);
  wire queue_free = ~queue_v_r | fe_queue_ready_i;
  wire bus_done   = cyc_r & (wb_ack_i | wb_err_i);

  wire cmd_redirect   = (fe_cmd_i.opcode == e_op_pc_redirect);
  wire cmd_misaligned = cmd_redirect & (fe_cmd_i.vaddr[1:0] != 2'b00);

  // Commands use the gap between bus cycles; a misaligned redirect also needs a queue slot
  wire cmd_take  = fe_cmd_v_i & ~cyc_r & (~cmd_misaligned | queue_free);
  wire mis_take  = cmd_take & cmd_misaligned;
  wire bus_start = (is_run | is_stall) & ~cyc_r & queue_free & ~fe_cmd_v_i;

  assign fe_cmd_yumi_o      = cmd_take;
  assign pc_io.redirect_v   = cmd_take & cmd_redirect & ~cmd_misaligned;
  assign pc_io.redirect_pc  = fe_cmd_i.vaddr;
  assign pc_io.next_pc_yumi = cyc_r & wb_ack_i;

  always_comb
  begin
    state_n = state_r;
    if (cmd_take)
    begin
      state_n = pc_io.redirect_v ? e_run : e_wait;
    end
    else if (is_run)
    begin
      if (cyc_r & wb_err_i)
        state_n = e_wait;
      else if (~cyc_r & ~queue_free)
        state_n = e_stall;
    end
    else if (is_stall & queue_free)
    begin
      state_n = e_run;
    end
  end

  // Build the next queue entry
  always_comb
  begin
    queue_n = '0;
    if (mis_take | (cyc_r & wb_err_i))
    begin
      queue_n.msg_type                   = e_fe_exception;
      queue_n.msg.exception.vaddr        = mis_take ? fe_cmd_i.vaddr : pc_io.next_pc;
      queue_n.msg.exception.exception_code = mis_take ? e_instr_misaligned
                                                      : e_instr_access_fault;
    end
    else
    begin
      queue_n.msg_type        = e_fe_fetch;
      queue_n.msg.fetch.pc    = pc_io.next_pc;
      queue_n.msg.fetch.instr = wb_dat_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r   <= e_wait;
      cyc_r     <= 1'b0;
      queue_v_r <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      if (bus_start)
        cyc_r <= 1'b1;
      else if (bus_done)
        cyc_r <= 1'b0;
      if (bus_done | mis_take)
        queue_v_r <= 1'b1;
      else if (fe_queue_ready_i)
        queue_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (bus_done | mis_take)
      queue_r <= queue_n;
  end

  assign fe_queue_o   = queue_r;
  assign fe_queue_v_o = queue_v_r;

  // Address is the held pc, which only moves on ack or redirect
  assign wb_adr_o = pc_io.next_pc;
  assign wb_cyc_o = cyc_r;
  assign wb_stb_o = cyc_r;
  assign wb_we_o  = 1'b0;

  a_stb_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (wb_stb_o && !wb_ack_i && !wb_err_i) |=> (wb_stb_o && $stable(wb_adr_o)))
    else $error("stb or adr changed before ack/err");

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_cyc_o |-> !(wb_ack_i && wb_err_i))
    else $error("ack and err both high");

  a_queue_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (fe_queue_v_o && !fe_queue_ready_i) |=> (fe_queue_v_o && $stable(fe_queue_o)))
    else $error("queue entry changed while not ready");

endmodule

`default_nettype wire

// ==== logic/fe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

module fe_top
(
  input  logic                       clk_i,
  input  logic                       reset_i,

  // Commands from the back end
  input  fe_cmd_pkg::fe_cmd_s        fe_cmd_i,
  input  logic                       fe_cmd_v_i,
  output logic                       fe_cmd_yumi_o,

  // Fetch queue
  output fe_queue_pkg::fe_queue_s    fe_queue_o,
  output logic                       fe_queue_v_o,
  input  logic                       fe_queue_ready_i,

  // Wishbone classic master toward instruction memory
  output logic [`FE_VADDR_W-1:0]     wb_adr_o,
  output logic                       wb_cyc_o,
  output logic                       wb_stb_o,
  output logic                       wb_we_o,
  input  logic [`FE_INSTR_W-1:0]     wb_dat_i,
  input  logic                       wb_ack_i,
  input  logic                       wb_err_i
);

  fe_pc_if u_pc_if ();

  fe_pc_gen u_pc_gen
  (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .pc_io   (u_pc_if.gen)
  );

  fe_fetch_ctrl u_fetch_ctrl
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fe_cmd_i         (fe_cmd_i),
    .fe_cmd_v_i       (fe_cmd_v_i),
    .fe_cmd_yumi_o    (fe_cmd_yumi_o),
    .fe_queue_o       (fe_queue_o),
    .fe_queue_v_o     (fe_queue_v_o),
    .fe_queue_ready_i (fe_queue_ready_i),
    .wb_adr_o         (wb_adr_o),
    .wb_cyc_o         (wb_cyc_o),
    .wb_stb_o         (wb_stb_o),
    .wb_we_o          (wb_we_o),
    .wb_dat_i         (wb_dat_i),
    .wb_ack_i         (wb_ack_i),
    .wb_err_i         (wb_err_i),
    .pc_io            (u_pc_if.ctrl)
  );

endmodule

`default_nettype wire

// ==== sim/wb_imem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

module wb_imem_model
#(
  parameter logic [`FE_VADDR_W-1:0] ERR_BASE = 32'h0000_1000
)
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic [`FE_VADDR_W-1:0] adr_i,
  input  logic                   cyc_i,
  input  logic                   stb_i,
  input  logic                   we_i,
  input  logic [1:0]             delay_i,
  output logic [`FE_INSTR_W-1:0] dat_o,
  output logic                   ack_o,
  output logic                   err_o
);

  logic                   busy_r;
  logic [1:0]             count_r;
  logic [`FE_VADDR_W-1:0] word;

  assign word = adr_i >> 2;

  // Reads only; a response is held off by delay_i cycles taken at the start of the cycle
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      busy_r  <= 1'b0;
      count_r <= 2'd0;
      ack_o   <= 1'b0;
      err_o   <= 1'b0;
      dat_o   <= '0;
    end
    else
    begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
      if (busy_r)
      begin
        if (count_r == 2'd0)
        begin
          busy_r <= 1'b0;
          if (adr_i >= ERR_BASE)
          begin
            err_o <= 1'b1;
          end
          else
          begin
            ack_o <= 1'b1;
            // Word index rotated left by 7 and then scrambled
            dat_o <= {word[24:0], word[31:25]} ^ 32'h5a5a_0000;
          end
        end
        else
        begin
          count_r <= count_r - 2'd1;
        end
      end
      else if (cyc_i && stb_i && !we_i && !ack_o && !err_o)
      begin
        busy_r  <= 1'b1;
        count_r <= delay_i;
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_fe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

module tb_fe_top;

  import fe_cmd_pkg::*;
  import fe_queue_pkg::*;

  localparam logic [`FE_VADDR_W-1:0] ERR_BASE = 32'h0000_1000;
  localparam int TIMEOUT = 2000;

  logic                   clk_i = 1'b0;
  logic                   reset_i;
  fe_cmd_s                fe_cmd_i;
  logic                   fe_cmd_v_i;
  logic                   fe_cmd_yumi_o;
  fe_queue_s              fe_queue_o;
  logic                   fe_queue_v_o;
  logic                   fe_queue_ready_i = 1'b1;
  logic [`FE_VADDR_W-1:0] wb_adr_o;
  logic                   wb_cyc_o;
  logic                   wb_stb_o;
  logic                   wb_we_o;
  logic [`FE_INSTR_W-1:0] wb_dat_i;
  logic                   wb_ack_i;
  logic                   wb_err_i;

  logic [31:0]            rng_state = 32'hb7c9_06ef;
  logic [1:0]             ack_delay = 2'd0;
  logic                   random_ready = 1'b0;

  // Expected stream state and a target that waits behind a held entry
  logic [`FE_VADDR_W-1:0] exp_pc = '0;
  logic                   exp_active = 1'b0;
  logic                   pend_v = 1'b0;
  logic [`FE_VADDR_W-1:0] pend_pc = '0;
  logic                   pend_active = 1'b0;
  fe_queue_s              exp_entry;
  int                     n_msgs = 0;

  // Address the next bus cycle must present
  logic [`FE_VADDR_W-1:0] bus_pc = '0;

  fe_top u_dut
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fe_cmd_i         (fe_cmd_i),
    .fe_cmd_v_i       (fe_cmd_v_i),
    .fe_cmd_yumi_o    (fe_cmd_yumi_o),
    .fe_queue_o       (fe_queue_o),
    .fe_queue_v_o     (fe_queue_v_o),
    .fe_queue_ready_i (fe_queue_ready_i),
    .wb_adr_o         (wb_adr_o),
    .wb_cyc_o         (wb_cyc_o),
    .wb_stb_o         (wb_stb_o),
    .wb_we_o          (wb_we_o),
    .wb_dat_i         (wb_dat_i),
    .wb_ack_i         (wb_ack_i),
    .wb_err_i         (wb_err_i)
  );

  wb_imem_model #(.ERR_BASE(ERR_BASE)) u_imem
  (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .adr_i   (wb_adr_o),
    .cyc_i   (wb_cyc_o),
    .stb_i   (wb_stb_o),
    .we_i    (wb_we_o),
    .delay_i (ack_delay),
    .dat_o   (wb_dat_i),
    .ack_o   (wb_ack_i),
    .err_o   (wb_err_i)
  );

  always
  begin
    #4;
    clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  always @(negedge clk_i)
  begin
    rng_state = lcg_step(rng_state);
    fe_queue_ready_i = random_ready ? rng_state[16] : 1'b1;
    ack_delay = rng_state[21:20];
  end

  function automatic logic [`FE_INSTR_W-1:0] imem_word(input logic [`FE_VADDR_W-1:0] addr);
    logic [31:0] w;
    w = addr >> 2;
    return {w[24:0], w[31:25]} ^ 32'h5a5a_0000;
  endfunction

  // Entry the front end must deliver for a given pc
  function automatic fe_queue_s expected_entry(input logic [`FE_VADDR_W-1:0] pc);
    fe_queue_s e;
    e = '0;
    if (pc[1:0] != 2'b00)
    begin
      e.msg_type = e_fe_exception;
      e.msg.exception.vaddr = pc;
      e.msg.exception.exception_code = e_instr_misaligned;
    end
    else if (pc >= ERR_BASE)
    begin
      e.msg_type = e_fe_exception;
      e.msg.exception.vaddr = pc;
      e.msg.exception.exception_code = e_instr_access_fault;
    end
    else
    begin
      e.msg_type = e_fe_fetch;
      e.msg.fetch.pc = pc;
      e.msg.fetch.instr = imem_word(pc);
    end
    return e;
  endfunction

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic report_failure(input string reason);
    $display("Failure: %s", reason);
    abort_run();
  endtask

  task automatic check_queue_entry(input fe_queue_s got, input fe_queue_s exp);
    if (got !== exp)
    begin
      $display("Error: fe_queue_o got %h expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_cmd_accept(input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Error: fe_cmd_yumi_o got %h expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_bus_addr(input logic [`FE_VADDR_W-1:0] got,
                                input logic [`FE_VADDR_W-1:0] exp);
    if (got !== exp)
    begin
      $display("Error: wb_adr_o got %h expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Error: %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  always @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      if (fe_queue_v_o && fe_queue_ready_i)
      begin
        if (!exp_active)
          report_failure("queue entry delivered when none was due");
        exp_entry = expected_entry(exp_pc);
        check_queue_entry(fe_queue_o, exp_entry);
        n_msgs++;
        if (exp_entry.msg_type == e_fe_exception)
          exp_active = 1'b0;
        else
          exp_pc = exp_pc + `FE_PC_STEP;
        if (pend_v)
        begin
          exp_pc = pend_pc;
          exp_active = pend_active;
          pend_v = 1'b0;
        end
      end
      check_bit("wb_we_o", wb_we_o, 1'b0);
      if (wb_cyc_o)
      begin
        check_bit("wb_stb_o", wb_stb_o, 1'b1);
        if (wb_ack_i || wb_err_i)
          check_bus_addr(wb_adr_o, bus_pc);
        if (wb_ack_i)
          bus_pc = bus_pc + `FE_PC_STEP;
      end
      // Commands wait for a closed bus cycle and misaligned ones for a free queue
      if (!fe_cmd_v_i || wb_cyc_o
          || ((fe_cmd_i.opcode == e_op_pc_redirect) && (fe_cmd_i.vaddr[1:0] != 2'b00)
              && fe_queue_v_o && !fe_queue_ready_i))
        check_cmd_accept(fe_cmd_yumi_o, 1'b0);
      if (fe_cmd_yumi_o)
      begin
        if (fe_cmd_i.opcode == e_op_pc_redirect)
          bus_pc = fe_cmd_i.vaddr;
        // A held entry still belongs to the old stream
        if (fe_queue_v_o && !fe_queue_ready_i)
        begin
          pend_v = 1'b1;
          pend_pc = fe_cmd_i.vaddr;
          pend_active = (fe_cmd_i.opcode == e_op_pc_redirect);
        end
        else
        begin
          exp_pc = fe_cmd_i.vaddr;
          exp_active = (fe_cmd_i.opcode == e_op_pc_redirect);
        end
      end
    end
  end

  task automatic send_cmd(input fe_cmd_opcode_e op, input logic [`FE_VADDR_W-1:0] vaddr);
    int waited;
    waited = 0;
    @(negedge clk_i);
    fe_cmd_i.opcode = op;
    fe_cmd_i.vaddr = vaddr;
    fe_cmd_v_i = 1'b1;
    forever
    begin
      @(posedge clk_i);
      if (fe_cmd_yumi_o)
        break;
      waited++;
      if (waited > TIMEOUT)
        report_failure("command was never consumed");
    end
    @(negedge clk_i);
    fe_cmd_v_i = 1'b0;
  endtask

  task automatic wait_msgs(input int count);
    int target;
    int waited;
    target = n_msgs + count;
    waited = 0;
    while (n_msgs < target)
    begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT)
        report_failure("timed out waiting for queue messages");
    end
  endtask

  task automatic wait_stream_end();
    int waited;
    waited = 0;
    while (exp_active || pend_v)
    begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT)
        report_failure("timed out waiting for the stream to end");
    end
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles)
    begin
      @(negedge clk_i);
      check_bit("fe_queue_v_o", fe_queue_v_o, 1'b0);
      check_bit("wb_cyc_o", wb_cyc_o, 1'b0);
      check_bit("wb_stb_o", wb_stb_o, 1'b0);
    end
  endtask

  initial
  begin
    reset_i = 1'b1;
    fe_cmd_i = '0;
    fe_cmd_v_i = 1'b0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    check_idle(20);

    // Sequential stream with the queue always ready
    send_cmd(e_op_pc_redirect, 32'h0000_0100);
    wait_msgs(12);
    send_cmd(e_op_halt, '0);
    wait_stream_end();
    check_idle(20);

    // Same stream under random back-pressure and then a redirect mid-stream
    random_ready = 1'b1;
    send_cmd(e_op_pc_redirect, 32'h0000_0100);
    wait_msgs(12);
    send_cmd(e_op_pc_redirect, 32'h0000_0800);
    wait_msgs(8);

    // Runs into the error range and ends with one access fault
    send_cmd(e_op_pc_redirect, ERR_BASE - 32'd12);
    wait_stream_end();
    check_idle(20);

    send_cmd(e_op_pc_redirect, 32'h0000_0206);
    wait_stream_end();
    check_idle(10);

    // Halt while fetching
    send_cmd(e_op_pc_redirect, 32'h0000_0300);
    wait_msgs(5);
    send_cmd(e_op_halt, '0);
    wait_stream_end();
    check_idle(30);

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+logic
logic/fe_cmd_pkg.sv
logic/fe_queue_pkg.sv
logic/fe_pc_if.sv
logic/fe_pc_gen.sv
logic/fe_fetch_ctrl.sv
logic/fe_top.sv
sim/wb_imem_model.sv
sim/tb_fe_top.sv

// ==== Makefile ====
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = tb_fe_top
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Test OK

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
